// ==== vlog.f ====
+incdir+design
design/ringBusPkg.sv
design/ringBridge.sv
design/ringRequester.sv
design/ringMemory.sv
design/ringSubsystem.sv
dv/ringSubsystem_chk.sv
dv/ringSubsystemTb.sv

// ==== Bender.yml ====
package:
  name: ring_subsystem

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/ringBusPkg.sv
      - design/ringBridge.sv
      - design/ringRequester.sv
      - design/ringMemory.sv
      - design/ringSubsystem.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/ringSubsystem_chk.sv
      - dv/ringSubsystemTb.sv

// ==== dv/ringSubsystemTb.sv ====
// **********************************************************
// ringSubsystemTb drives loads and stores through both rings
// and the bound checker judges every response
// **********************************************************
`include "ringBus_config.svh"

module ringSubsystemTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int waitLimit = 100;   // cycles allowed per wait
	localparam int randOps   = 300;   // length of the random run

	logic                   clock;
	logic                   reset;
	logic                   reqValid;
	logic                   reqStore;
	ringBusPkg::addrT       reqAddr;
	ringBusPkg::tileT       reqData;
	logic [`RING_TAG_W-1:0] reqTag;
	logic                   reqReady;
	logic                   respValid;
	logic [`RING_TAG_W-1:0] respTag;
	ringBusPkg::tileT       respData;

	int                     passCount;
	int                     failCount;
	int                     timeouts;    // waits that ran out
	int                     errBase;     // checker count at test start
	int                     toBase;      // timeouts at test start
	logic [`RING_TAG_W-1:0] nextTag;     // tag for the next request
	ringBusPkg::addrT       pool[$];     // addresses written so far

	ringSubsystem DUT (
		.clock     (clock),
		.reset     (reset),
		.reqValid  (reqValid),
		.reqStore  (reqStore),
		.reqAddr   (reqAddr),
		.reqData   (reqData),
		.reqTag    (reqTag),
		.reqReady  (reqReady),
		.respValid (respValid),
		.respTag   (respTag),
		.respData  (respData)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;   // 8 ns period
	end

	// one request from waiting for reqReady to its respValid
	task automatic access(input logic store, input ringBusPkg::addrT addr,
		input ringBusPkg::tileT data);
		int cycles;
		cycles = 0;
		while (!reqReady && cycles < waitLimit)
		begin
			@(posedge clock);
			cycles++;
		end
		if (!reqReady)
		begin
			$display("timeout: reqReady stayed low for %0d cycles at %0t", waitLimit, $time);
			timeouts++;
			return;
		end
		reqValid <= 1'b1;
		reqStore <= store;
		reqAddr  <= addr;
		reqData  <= data;
		reqTag   <= nextTag;
		nextTag = nextTag + 1'b1;
		@(posedge clock);   // accepted here
		reqValid <= 1'b0;
		cycles = 0;
		do
		begin
			@(posedge clock);
			cycles++;
		end while (!respValid && cycles < waitLimit);
		if (!respValid)
		begin
			$display("timeout: no response within %0d cycles at %0t", waitLimit, $time);
			timeouts++;
		end
	endtask

	task automatic startTest();
		errBase = DUT.chk.errCount;
		toBase  = timeouts;
	endtask

	task automatic finishTest(input string name);
		int problems;
		@(posedge clock);   // let the last response be judged
		problems = (DUT.chk.errCount - errBase) + (timeouts - toBase);
		if (problems == 0)
		begin
			passCount++;
			$display("test %s: ok", name);
		end
		else
		begin
			failCount++;
			$display("test %s: %0d problems", name, problems);
		end
	endtask

	initial
	begin
		ringBusPkg::addrT addr;
		int               order[$];
		int               j;
		int               tmp;
		void'($urandom(43));
		reset     = 1'b1;
		reqValid  = 1'b0;
		reqStore  = 1'b0;
		reqAddr   = '0;
		reqData   = '0;
		reqTag    = '0;
		nextTag   = '0;
		passCount = 0;
		failCount = 0;
		timeouts  = 0;

		startTest();   // reset state belongs to the first test
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		repeat (12) @(posedge clock);   // idle so no response may appear
		finishTest("resetIdle");

		startTest();
		addr = 32'h40;
		access(1'b1, addr, 64'hdead_beef_0123_4567);
		access(1'b0, addr, '0);
		pool.push_back(addr);
		finishTest("storeLoad");

		startTest();
		for (int i = 0; i < 8; i++)
		begin
			addr = 32'h100 + i * 8;   // distinct words
			access(1'b1, addr, {$urandom(), $urandom()});
			pool.push_back(addr);
			order.push_back(i);
		end
		for (int i = 0; i < 8; i += 2)
			access(1'b1, 32'h100 + i * 8, {$urandom(), $urandom()});   // newer value
		for (int i = order.size() - 1; i > 0; i--)
		begin
			j        = $urandom_range(i, 0);
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		foreach (order[k])
			access(1'b0, 32'h100 + order[k] * 8, '0);
		finishTest("shuffledLoads");

		startTest();
		addr = 32'h18;
		access(1'b1, addr, 64'h1111_2222_3333_4444);
		access(1'b1, addr, 64'h5555_6666_7777_8888);   // overwrite
		access(1'b0, addr, '0);
		pool.push_back(addr);
		finishTest("overwrite");

		startTest();
		for (int i = 0; i < randOps; i++)
		begin
			addr = pool[$urandom_range(pool.size() - 1, 0)];
			access(1'($urandom_range(1, 0)), addr, {$urandom(), $urandom()});
		end
		finishTest("randomRun");

		$display("tests passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== dv/ringSubsystem_chk.sv ====
// **********************************************************
// ringSubsystemChk: word model of the L2 memory, judges the
// reset state, response tags and load data
// **********************************************************
`include "ringBus_config.svh"

module ringSubsystemChk (
	input logic                   clock,
	input logic                   reset,
	input logic                   reqValid,
	input logic                   reqStore,
	input ringBusPkg::addrT       reqAddr,
	input ringBusPkg::tileT       reqData,
	input logic [`RING_TAG_W-1:0] reqTag,
	input logic                   reqReady,
	input logic                   respValid,
	input logic [`RING_TAG_W-1:0] respTag,
	input ringBusPkg::tileT       respData,
	input ringBusPkg::ringMsgT    l1Up,
	input ringBusPkg::ringMsgT    l1Down,
	input ringBusPkg::ringMsgT    l2Down,
	input ringBusPkg::ringMsgT    l2Up
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ofsW = $clog2(`RING_DATA_W / 8);   // bytes in a tile
	localparam int idxW = $clog2(`RING_MEM_WORDS);

	int                     errCount = 0;
	ringBusPkg::tileT       model [`RING_MEM_WORDS];
	logic [`RING_MEM_WORDS-1:0] written;       // words with a known value
	logic                   outstanding;       // request accepted, no response yet
	logic                   outStore;
	logic [`RING_TAG_W-1:0] outTag;
	logic [idxW-1:0]        outIdx;
	logic                   accepted;
	logic                   ringsIdle;
	ringBusPkg::tileT       expData;

	assign accepted  = reqValid && reqReady;
	assign expData   = model[outIdx];
	assign ringsIdle = l1Up.opm == ringBusPkg::opmIdle && l1Down.opm == ringBusPkg::opmIdle &&
		l2Down.opm == ringBusPkg::opmIdle && l2Up.opm == ringBusPkg::opmIdle;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			outstanding <= 1'b0;
			written     <= '0;
		end
		else
		begin
			if (respValid)
				outstanding <= 1'b0;
			if (accepted)   // a new accept wins over the clear
			begin
				outstanding <= 1'b1;
				outStore    <= reqStore;
				outTag      <= reqTag;
				outIdx      <= reqAddr[ofsW +: idxW];
				if (reqStore)
				begin
					model[reqAddr[ofsW +: idxW]]   <= reqData;
					written[reqAddr[ofsW +: idxW]] <= 1'b1;
				end
			end
		end
	end

	assert property (@(posedge clock) reset |=> ringsIdle && reqReady && !respValid)
	else
	begin
		errCount++;
		$error("ERR %0t: rings or flags not idle after reset", $time);
	end

	assert property (@(posedge clock) disable iff (reset) respValid |-> outstanding)
	else
	begin
		errCount++;
		$error("ERR %0t: respValid with no outstanding request", $time);
	end

	assert property (@(posedge clock) disable iff (reset) respValid |-> respTag == outTag)
	else
	begin
		errCount++;
		$error("ERR %0t: respTag %0h, expected %0h", $time, $sampled(respTag), $sampled(outTag));
	end

	assert property (@(posedge clock) disable iff (reset)
		respValid && !outStore && written[outIdx] |-> respData == expData)
	else
	begin
		errCount++;
		$error("ERR %0t: load data %0h, expected %0h", $time, $sampled(respData),
			$sampled(expData));
	end

endmodule

bind ringSubsystem ringSubsystemChk chk (.*);

// ==== design/ringSubsystem.sv ====
// **********************************************************
// ringSubsystem: requester, bridge and memory on two rings
// **********************************************************
`include "ringBus_config.svh"

module ringSubsystem (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    reqValid,
	input  logic                    reqStore,
	input  ringBusPkg::addrT        reqAddr,
	input  ringBusPkg::tileT        reqData,
	input  logic [`RING_TAG_W-1:0]  reqTag,
	output logic                    reqReady,
	output logic                    respValid,
	output logic [`RING_TAG_W-1:0]  respTag,
	output ringBusPkg::tileT        respData
);

	ringBusPkg::ringMsgT l1Up;     // requester to bridge
	ringBusPkg::ringMsgT l1Down;   // bridge to requester
	ringBusPkg::ringMsgT l2Down;   // bridge to memory
	ringBusPkg::ringMsgT l2Up;     // memory to bridge

	ringRequester requester (
		.clock     (clock),
		.reset     (reset),
		.reqValid  (reqValid),
		.reqStore  (reqStore),
		.reqAddr   (reqAddr),
		.reqData   (reqData),
		.reqTag    (reqTag),
		.reqReady  (reqReady),
		.respValid (respValid),
		.respTag   (respTag),
		.respData  (respData),
		.l1In      (l1Down),
		.l1Out     (l1Up)
	);

	ringBridge bridge (
		.clock (clock),
		.reset (reset),
		.l1In  (l1Up),
		.l2In  (l2Up),
		.l1Out (l1Down),
		.l2Out (l2Down)
	);

	ringMemory memory (
		.clock   (clock),
		.reset   (reset),
		.ringIn  (l2Down),
		.ringOut (l2Up)
	);

endmodule

// ==== design/ringMemory.sv ====
// **********************************************************
// ringMemory: L2 ring node, a word memory that turns load and
// store requests into responses in the same slot
// **********************************************************
`include "ringBus_config.svh"

module ringMemory (
	input  logic                clock,
	input  logic                reset,
	input  ringBusPkg::ringMsgT ringIn,
	output ringBusPkg::ringMsgT ringOut
);

	localparam int wordOfsW = $clog2(`RING_DATA_W / 8);   // byte offset inside a tile
	localparam int memIdxW  = $clog2(`RING_MEM_WORDS);

	ringBusPkg::tileT mem [0:`RING_MEM_WORDS-1];

	logic [memIdxW-1:0] wordIdx;   // low address bits above the offset
	logic               isLoad;
	logic               isStore;

	assign wordIdx = ringIn.addr[wordOfsW +: memIdxW];
	assign isLoad  = (ringIn.opm == ringBusPkg::opmLoadReq);
	assign isStore = (ringIn.opm == ringBusPkg::opmStoreReq);

	// write port
	always_ff @(posedge clock)
	begin
		if (isStore)
			mem[wordIdx] <= ringIn.data;
	end

	// seq and addr stay, so the bridge can route the response home
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ringOut <= '0;   // empty slot
		end
		else
		begin
			ringOut <= ringIn;   // forward by default
			if (isStore)
			begin
				ringOut.opm <= ringBusPkg::opmStoreResp;   // data echoed back
			end
			else if (isLoad)
			begin
				ringOut.opm  <= ringBusPkg::opmLoadResp;
				ringOut.data <= mem[wordIdx];   // old word, read before write
			end
		end
	end

endmodule

// ==== design/ringRequester.sv ====
// **********************************************************
// ringRequester: L1 ring node, puts one load or store on the
// ring and catches the response with its tag
// **********************************************************
`include "ringBus_config.svh"

module ringRequester (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    reqValid,   // one-cycle request strobe
	input  logic                    reqStore,   // store, else load
	input  ringBusPkg::addrT        reqAddr,
	input  ringBusPkg::tileT        reqData,
	input  logic [`RING_TAG_W-1:0]  reqTag,
	output logic                    reqReady,   // no request outstanding
	output logic                    respValid,  // one-cycle completion strobe
	output logic [`RING_TAG_W-1:0]  respTag,
	output ringBusPkg::tileT        respData,
	input  ringBusPkg::ringMsgT     l1In,
	output ringBusPkg::ringMsgT     l1Out
);

	localparam ringBusPkg::nodeIdT clusterId = ringBusPkg::nodeIdT'(`RING_CLUSTER_ID);

	ringBusPkg::reqStateT state;
	ringBusPkg::ringMsgT  pendMsg;   // the latched request
	logic                 slotFree;  // empty slot passing by
	logic                 ownResp;   // response to the pending request

	assign slotFree = (l1In.opm == ringBusPkg::opmIdle);
	assign ownResp  = ringBusPkg::isResp(l1In.opm) && (l1In.seq == pendMsg.seq);
	assign reqReady = (state == ringBusPkg::stIdle);

	// latch the request, seq carries our node id over the tag
	always_ff @(posedge clock)
	begin
		if (reqValid && reqReady)
		begin
			pendMsg.seq  <= {clusterId, reqTag};
			if (reqStore)
				pendMsg.opm <= ringBusPkg::opmStoreReq;
			else
				pendMsg.opm <= ringBusPkg::opmLoadReq;
			pendMsg.addr <= reqAddr;
			pendMsg.data <= reqData;   // ignored by loads
		end
	end

	// response payload
	always_ff @(posedge clock)
	begin
		if (state == ringBusPkg::stWaitResp && ownResp)
		begin
			respTag  <= l1In.seq[`RING_TAG_W-1:0];
			respData <= l1In.data;   // loaded word, or the echoed store
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state     <= ringBusPkg::stIdle;
			respValid <= 1'b0;
			l1Out     <= '0;   // empty slot
		end
		else
		begin
			respValid <= 1'b0;
			l1Out     <= l1In;   // pass through by default
			case (state)
				ringBusPkg::stIdle:
				begin
					if (reqValid)
						state <= ringBusPkg::stWaitSlot;
				end
				ringBusPkg::stWaitSlot:
				begin
					if (slotFree)
					begin
						l1Out <= pendMsg;   // take the slot
						state <= ringBusPkg::stWaitResp;
					end
				end
				ringBusPkg::stWaitResp:
				begin
					if (ownResp)
					begin
						respValid <= 1'b1;
						l1Out     <= '0;   // consume, slot goes free
						state     <= ringBusPkg::stIdle;
					end
				end
				default:
					state <= ringBusPkg::stIdle;
			endcase
		end
	end

endmodule

// ==== design/ringBridge.sv ====
// **********************************************************
// ringBridge: links the L1 ring to the L2 ring, requests go
// down and this cluster's responses come back up
// **********************************************************
`include "ringBus_config.svh"

module ringBridge (
	input  logic                clock,
	input  logic                reset,
	input  ringBusPkg::ringMsgT l1In,    // slot arriving from the L1 ring
	input  ringBusPkg::ringMsgT l2In,    // slot arriving from the L2 ring
	output ringBusPkg::ringMsgT l1Out,   // slot leaving onto the L1 ring
	output ringBusPkg::ringMsgT l2Out    // slot leaving onto the L2 ring
);

	localparam ringBusPkg::nodeIdT clusterId = ringBusPkg::nodeIdT'(`RING_CLUSTER_ID);

	logic l1Idle;     // empty slot on L1
	logic l1IsReq;    // request, wants to go down
	logic l2Idle;     // empty slot on L2
	logic l2IsResp;   // response for us, wants to go up
	logic l2IsOther;  // anything else that stays on L2

	logic holdL1;     // L1 slot busy with something that must stay
	logic holdL2;     // L2 slot busy with something that must stay

	logic takeL1;     // L1 output gets the crossing message
	logic takeL2;     // L2 output gets the crossing message

	ringBusPkg::ringMsgT toL1;   // response heading up, or empty
	ringBusPkg::ringMsgT toL2;   // request heading down, or empty

	// slot classes
	always_comb
	begin
		l1Idle    = (l1In.opm == ringBusPkg::opmIdle);
		l1IsReq   = ringBusPkg::isReq(l1In.opm);
		l2Idle    = (l2In.opm == ringBusPkg::opmIdle);
		l2IsResp  = ringBusPkg::isResp(l2In.opm) &&
			(ringBusPkg::seqNode(l2In.seq) == clusterId);
		l2IsOther = !l2Idle && !l2IsResp;   // request or foreign response
	end

	// hold conditions, a busy slot that cannot be swapped
	always_comb
	begin
		holdL1 = !l1Idle && !l1IsReq;   // response circling on L1
		holdL2 = l2IsOther;             // traffic that belongs to L2
	end

	// messages that would cross, empty when nothing crosses
	always_comb
	begin
		toL1 = '0;
		toL2 = '0;
		if (l2IsResp)
			toL1 = l2In;   // response climbs to L1
		if (l1IsReq)
			toL2 = l1In;   // request drops to L2
	end

	// L1 side frees or swaps its slot when the request can leave
	// L2 side frees or swaps its slot when the response can leave
	always_comb
	begin
		takeL1 = l1Idle || (l1IsReq && !holdL2);
		takeL2 = l2Idle || (l2IsResp && !holdL1);
	end

	// one register per direction
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			l1Out <= '0;   // empty slot, opm idle
			l2Out <= '0;
		end
		else
		begin
			if (takeL1)
				l1Out <= toL1;   // insert response or free the slot
			else
				l1Out <= l1In;   // forward unchanged

			if (takeL2)
				l2Out <= toL2;   // insert request or free the slot
			else
				l2Out <= l2In;   // forward unchanged
		end
	end

endmodule

// ==== design/ringBusPkg.sv ====
// **********************************************************
// ring bus types: field widths, operation modes, the ring
// message and the requester states
// **********************************************************
`include "ringBus_config.svh"

package ringBusPkg;

	typedef logic [`RING_SEQ_W-1:0] seqT;                  // node id in 15:10, tag in 9:0
	typedef logic [`RING_SEQ_W-`RING_TAG_W-1:0] nodeIdT;   // source node, upper seq bits
	typedef logic [`RING_ADDR_W-1:0] addrT;                // byte address
	typedef logic [`RING_DATA_W-1:0] tileT;                // data tile

	// top two bits give the class, 10 request and 01 response
	typedef enum logic [7:0] {
		opmIdle      = 8'h00,   // empty slot
		opmLoadReq   = 8'h80,
		opmStoreReq  = 8'h81,
		opmLoadResp  = 8'h40,   // data holds the loaded word
		opmStoreResp = 8'h41    // store done, data echoed
	} opmT;

	typedef struct packed {
		seqT  seq;   // who asked and which tag
		opmT  opm;   // operation mode
		addrT addr;
		tileT data;
	} ringMsgT;

	typedef enum logic [1:0] {
		stIdle,      // free for a new request
		stWaitSlot,  // request latched, no slot yet
		stWaitResp   // request on the ring
	} reqStateT;

	function automatic logic isReq(opmT opm);
		return opm[7:6] == 2'b10;   // request class
	endfunction

	function automatic logic isResp(opmT opm);
		return opm[7:6] == 2'b01;   // response class
	endfunction

	function automatic nodeIdT seqNode(seqT seq);
		return seq[`RING_SEQ_W-1:`RING_TAG_W];   // source node of a message
	endfunction

endpackage

// ==== design/ringBus_config.svh ====
// **********************************************************
// ring bus config: message field widths, memory depth and
// the node id of this cluster
// **********************************************************
`ifndef RINGBUS_CONFIG_SVH
`define RINGBUS_CONFIG_SVH

`define RING_ADDR_W     32      // address field of a ring message
`define RING_DATA_W     64      // one data tile per message
`define RING_SEQ_W      16      // sequence word, node id over tag
`define RING_TAG_W      10      // low seq bits, requester tag

`define RING_MEM_WORDS  64      // depth of the L2 memory node

// 8-bit node id of this cluster, only bits 7:2 travel in seq
`define RING_NODE_ID    8'h24
`define RING_CLUSTER_ID (`RING_NODE_ID >> 2)

`endif
